/* hdl/fetch_pkg.sv */
// Fetch front end constants
package fetch_pkg;

	// ------------------------------------------------------------------------
	// Bus geometry

	// Width of the fetch address presented on the bus
	localparam int unsigned addr_w = 32;

	// Width of one data beat returned by the memory
	localparam int unsigned data_w = 32;

	// Each data beat carries this many instruction halfwords
	localparam int unsigned hw_count = 2;

	// ------------------------------------------------------------------------
	// Prefetch and pipelining

	// Two entries are the minimum that keep the bus busy while decode stalls
	localparam int unsigned queue_depth = 2;

	// Upper bound on addresses issued whose data beat has not yet returned
	localparam int unsigned max_pending = 2;

	// ------------------------------------------------------------------------
	// Reset behaviour

	// First instruction address fetched once reset is released
	localparam logic [addr_w-1:0] reset_vector = 32'h0000_0040;

endpackage

/* hdl/rvc_pkg.sv */
// Compressed instruction encoding
package rvc_pkg;

	// Instructions are built from halfwords of this width
	localparam int unsigned hw_w = 16;

	// Length class taken from the two lowest opcode bits
	// Quadrants 0 to 2 hold 16-bit instructions and the last one
	// marks a full 32-bit instruction
	typedef enum logic [1:0] {
		quad_c0   = 2'b00,
		quad_c1   = 2'b01,
		quad_c2   = 2'b10,
		quad_full = 2'b11
	} len_class_e;

endpackage

/* hdl/fetch_request.sv */
// Fetch request generator
`timescale 1ns/1ps

module fetch_request (
	input  logic                              clk,
	input  logic                              rst_n,

	// Jump request from decode
	input  logic [fetch_pkg::addr_w-1:0]      jump_target,
	input  logic                              jump_target_vld,
	output logic                              jump_target_rdy,
	output logic                              jump_now,

	// Address phase of the fetch bus
	output logic [fetch_pkg::addr_w-1:0]      mem_addr,
	output logic                              mem_addr_vld,
	input  logic                              mem_addr_rdy,
	input  logic                              mem_data_vld,

	// Prefetch queue and assembly status
	input  logic                              queue_full,
	input  logic                              queue_almost_full,
	input  logic                              head_valid,
	input  logic                              room,

	// Qualifiers for the arriving data beat
	output logic                              data_live,
	output logic                              push,
	output logic [fetch_pkg::hw_count-1:0]    data_hwvld
);

	// Fetch address runs ahead of decode in whole words
	logic [fetch_pkg::addr_w-1:0] fetch_addr;
	logic [fetch_pkg::addr_w-1:0] req_addr;
	logic                         req_vld;
	logic                         reset_holdoff;
	logic                         addr_hold;
	logic                         fetch_stall;
	logic                         pending_full;
	logic                         issue;
	logic                         accept;
	logic [1:0]                   pending;
	logic [1:0]                   flush_pending;

	// ------------------------------------------------------------------------
	// Address phase

	// Throttle so that every beat already requested has somewhere to land
	assign pending_full = pending >= 2'(fetch_pkg::max_pending);
	assign fetch_stall  = queue_full || (queue_almost_full && |pending) || pending_full;

	// Priority is held address, then jump target, then the sequential address
	always_comb begin
		req_addr = fetch_addr;
		req_vld  = 1'b1;
		if (addr_hold) begin
			req_addr = fetch_addr;
		end else if (jump_target_vld) begin
			req_addr = {jump_target[fetch_pkg::addr_w-1:2], 2'b00};
			// The queue is about to be flushed, so only the outstanding count limits
			req_vld  = !pending_full;
		end else if (fetch_stall) begin
			req_vld  = 1'b0;
		end
	end

	assign mem_addr     = req_addr;
	assign mem_addr_vld = req_vld && !reset_holdoff;

	// A new address is counted the first cycle it appears, not when accepted
	assign issue  = mem_addr_vld && !addr_hold;
	assign accept = mem_addr_vld && mem_addr_rdy;

	// Jumps are refused only while an address phase must stay stable
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= fetch_pkg::reset_vector;
		end else if (jump_now) begin
			// Skip ahead one word when the target went out on the bus this cycle
			fetch_addr <= {jump_target[fetch_pkg::addr_w-1:2] +
				{{(fetch_pkg::addr_w-3){1'b0}}, accept}, 2'b00};
		end else if (accept) begin
			fetch_addr <= fetch_addr + {{(fetch_pkg::addr_w-3){1'b0}}, 3'd4};
		end
	end

	// No request goes out in the first cycle after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
		end else begin
			reset_holdoff <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// Bus pipeline tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_hold     <= 1'b0;
			pending       <= 2'd0;
			flush_pending <= 2'd0;
		end else begin
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending   <= pending + {1'b0, issue} - {1'b0, mem_data_vld};
			if (jump_now) begin
				// Every beat still in flight belongs to the old stream
				flush_pending <= pending - {1'b0, mem_data_vld};
			end else if (|flush_pending && mem_data_vld) begin
				flush_pending <= flush_pending - 2'd1;
			end
		end
	end

	assign data_live = mem_data_vld && (flush_pending == 2'd0);

	// Data goes straight to the CIR when the queue is empty and there is room
	assign push = data_live && !(room && !head_valid);

	// The first live beat after a jump to an odd halfword has its low half invalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_hwvld <= 2'b11;
		end else if (jump_now) begin
			data_hwvld <= {1'b1, !jump_target[1]};
		end else if (data_live) begin
			data_hwvld <= 2'b11;
		end
	end

endmodule

/* hdl/prefetch_queue.sv */
// Prefetch word queue
`timescale 1ns/1ps

module prefetch_queue (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              flush,
	input  logic                              push,
	input  logic                              pop,
	input  logic [fetch_pkg::data_w-1:0]      mem_data,
	input  logic                              mem_data_err,
	input  logic [fetch_pkg::hw_count-1:0]    data_hwvld,
	output logic [fetch_pkg::data_w-1:0]      head_data,
	output logic [fetch_pkg::hw_count-1:0]    head_hwvld,
	output logic                              head_err,
	output logic                              head_valid,
	output logic                              queue_full,
	output logic                              queue_almost_full
);

	// Entry 0 is the head and valid entries are always packed from it
	logic [fetch_pkg::data_w-1:0]   q_data  [fetch_pkg::queue_depth];
	logic [fetch_pkg::hw_count-1:0] q_hwvld [fetch_pkg::queue_depth];
	logic [fetch_pkg::queue_depth-1:0] q_err;
	logic [fetch_pkg::queue_depth-1:0] q_valid;

	// Views extended by one slot past the tail, where the bus word sits
	logic [fetch_pkg::data_w-1:0]   ext_data  [fetch_pkg::queue_depth+1];
	logic [fetch_pkg::hw_count-1:0] ext_hwvld [fetch_pkg::queue_depth+1];
	logic [fetch_pkg::queue_depth:0] ext_err;
	logic [fetch_pkg::queue_depth:0] ext_valid;
	// Entry below each slot is valid, with entry -1 treated as always valid
	logic [fetch_pkg::queue_depth:0] below_valid;

	always_comb begin
		for (int i = 0; i < fetch_pkg::queue_depth; i++) begin
			q_valid[i]   = |q_hwvld[i];
			ext_data[i]  = q_data[i];
			ext_hwvld[i] = q_hwvld[i];
		end
		ext_data[fetch_pkg::queue_depth]  = mem_data;
		ext_hwvld[fetch_pkg::queue_depth] = '0;
	end

	assign ext_err     = {mem_data_err, q_err};
	assign ext_valid   = {1'b0, q_valid};
	assign below_valid = {q_valid, 1'b1};

	// ------------------------------------------------------------------------
	// Payload shifts down on a pop and takes the bus word in free slots

	always_ff @(posedge clk) begin
		for (int i = 0; i < fetch_pkg::queue_depth; i++) begin
			if (pop || (push && !q_valid[i])) begin
				q_data[i] <= ext_valid[i+1] ? ext_data[i+1] : mem_data;
				q_err[i]  <= ext_valid[i+1] ? ext_err[i+1] : mem_data_err;
			end
		end
	end

	// Halfword masks decide which slots really hold data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < fetch_pkg::queue_depth; i++) begin
				q_hwvld[i] <= '0;
			end
		end else begin
			for (int i = 0; i < fetch_pkg::queue_depth; i++) begin
				if (flush) begin
					q_hwvld[i] <= '0;
				end else if (ext_valid[i+1] && pop) begin
					q_hwvld[i] <= ext_hwvld[i+1];
				end else if (q_valid[i] && pop) begin
					// Last valid entry leaves and the new word, if any, drops in
					q_hwvld[i] <= push ? data_hwvld : '0;
				end else if (!q_valid[i] && below_valid[i] && push && !pop) begin
					q_hwvld[i] <= data_hwvld;
				end
			end
		end
	end

	assign head_data         = q_data[0];
	assign head_hwvld        = q_hwvld[0];
	assign head_err          = q_err[0];
	assign head_valid        = q_valid[0];
	assign queue_full        = q_valid[fetch_pkg::queue_depth-1];
	assign queue_almost_full = q_valid[fetch_pkg::queue_depth-2];

endmodule

/* hdl/instr_assembly.sv */
// Instruction assembly into CIR
`timescale 1ns/1ps

module instr_assembly (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              jump_now,
	input  logic                              cir_flush_behind,

	// Bus word for the bypass path
	input  logic [fetch_pkg::data_w-1:0]      mem_data,
	input  logic                              mem_data_err,
	input  logic                              data_live,
	input  logic [fetch_pkg::hw_count-1:0]    data_hwvld,

	// Head of the prefetch queue
	input  logic [fetch_pkg::data_w-1:0]      head_data,
	input  logic [fetch_pkg::hw_count-1:0]    head_hwvld,
	input  logic                              head_err,
	input  logic                              head_valid,

	// Decode side
	input  logic [1:0]                        cir_use,
	output logic [31:0]                       cir,
	output logic [1:0]                        cir_vld,
	output logic [1:0]                        cir_err,
	output logic                              room,
	output logic                              pop
);

	// Third halfword sits above the CIR and buf_level counts all valid halfwords
	logic [rvc_pkg::hw_w-1:0]       hwbuf;
	logic [1:0]                     buf_level;
	logic [2:0]                     err_q;

	logic [fetch_pkg::data_w-1:0]   fetch_data;
	logic [fetch_pkg::hw_count-1:0] fetch_hwvld;
	logic                           fetch_err;
	logic                           fetch_vld;
	logic [fetch_pkg::data_w-1:0]   fetch_aligned;

	logic [3*rvc_pkg::hw_w-1:0]     data_shifted;
	logic [3*rvc_pkg::hw_w-1:0]     data_next;
	logic [2:0]                     err_shifted;
	logic [2:0]                     err_next;
	logic [1:0]                     level_keep;
	logic [1:0]                     fill;
	logic [1:0]                     level_next;
	rvc_pkg::len_class_e            cir_class;

	// ------------------------------------------------------------------------
	// Fetch source

	// The queue head is older than anything on the bus so it always wins
	assign fetch_data  = head_valid ? head_data : mem_data;
	assign fetch_hwvld = head_valid ? head_hwvld : data_hwvld;
	assign fetch_err   = head_valid ? head_err : mem_data_err;
	assign fetch_vld   = head_valid || data_live;

	// Odd start words bring their upper halfword down into the low slot
	assign fetch_aligned = {
		fetch_data[rvc_pkg::hw_w +: rvc_pkg::hw_w],
		fetch_hwvld[0] ? fetch_data[0 +: rvc_pkg::hw_w] :
			fetch_data[rvc_pkg::hw_w +: rvc_pkg::hw_w]
	};

	// ------------------------------------------------------------------------
	// Shift out consumed halfwords

	// Slots that end up unused are filled with whatever costs least
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[rvc_pkg::hw_w +: rvc_pkg::hw_w], hwbuf};
			err_shifted  = err_q >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir[rvc_pkg::hw_w +: rvc_pkg::hw_w]};
			err_shifted  = err_q >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted  = err_q;
		end
	end

	assign level_keep = buf_level - cir_use;

	// A full word needs two free slots and a single halfword needs one
	assign room = level_keep <= (&fetch_hwvld ? 2'd1 : 2'd2);
	assign pop  = room && head_valid;

	// ------------------------------------------------------------------------
	// Overlay fresh halfwords at the current level

	always_comb begin
		if (!room) begin
			data_next = data_shifted;
			err_next  = err_shifted;
		end else if (level_keep[1]) begin
			data_next = {fetch_aligned[0 +: rvc_pkg::hw_w], data_shifted[0 +: 2*rvc_pkg::hw_w]};
			err_next  = {fetch_err, err_shifted[1:0]};
		end else if (level_keep[0]) begin
			data_next = {fetch_aligned, data_shifted[0 +: rvc_pkg::hw_w]};
			err_next  = {{2{fetch_err}}, err_shifted[0]};
		end else begin
			data_next = {data_shifted[2*rvc_pkg::hw_w +: rvc_pkg::hw_w], fetch_aligned};
			err_next  = {err_shifted[2], {2{fetch_err}}};
		end
	end

	assign fill = (room && fetch_vld) ? (&fetch_hwvld ? 2'd2 : 2'd1) : 2'd0;

	// Flush-behind keeps exactly the oldest instruction, sized by its opcode
	assign cir_class = rvc_pkg::len_class_e'(cir[1:0]);

	always_comb begin
		if (jump_now && cir_flush_behind) begin
			level_next = (cir_class == rvc_pkg::quad_full) ? 2'd2 : 2'd1;
		end else if (jump_now) begin
			level_next = 2'd0;
		end else begin
			level_next = level_keep + fill;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld   <= 2'd0;
			err_q     <= 3'b000;
			hwbuf     <= '0;
			cir       <= '0;
		end else begin
			buf_level     <= level_next;
			// Decode only ever sees up to two halfwords
			cir_vld       <= (level_next == 2'd3) ? 2'd2 : level_next;
			err_q         <= err_next;
			{hwbuf, cir}  <= data_next;
		end
	end

	assign cir_err = err_q[1:0];

endmodule

/* hdl/fetch_frontend.sv */
// Instruction fetch front end
`timescale 1ns/1ps

module fetch_frontend (
	input  logic                              clk,
	input  logic                              rst_n,

	// Fetch bus
	output logic [fetch_pkg::addr_w-1:0]      mem_addr,
	output logic                              mem_addr_vld,
	input  logic                              mem_addr_rdy,
	input  logic [fetch_pkg::data_w-1:0]      mem_data,
	input  logic                              mem_data_err,
	input  logic                              mem_data_vld,

	// Jump port
	input  logic [fetch_pkg::addr_w-1:0]      jump_target,
	input  logic                              jump_target_vld,
	output logic                              jump_target_rdy,
	input  logic                              cir_flush_behind,

	// Decode port
	output logic [31:0]                       cir,
	output logic [1:0]                        cir_vld,
	output logic [1:0]                        cir_err,
	input  logic [1:0]                        cir_use
);

	logic                           jump_now;
	logic                           data_live;
	logic                           push;
	logic                           pop;
	logic                           room;
	logic [fetch_pkg::hw_count-1:0] data_hwvld;
	logic [fetch_pkg::data_w-1:0]   head_data;
	logic [fetch_pkg::hw_count-1:0] head_hwvld;
	logic                           head_err;
	logic                           head_valid;
	logic                           queue_full;
	logic                           queue_almost_full;

	// Address generation and bus tracking
	fetch_request i_request (
		.clk               (clk),
		.rst_n             (rst_n),
		.jump_target       (jump_target),
		.jump_target_vld   (jump_target_vld),
		.jump_target_rdy   (jump_target_rdy),
		.jump_now          (jump_now),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.mem_data_vld      (mem_data_vld),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full),
		.head_valid        (head_valid),
		.room              (room),
		.data_live         (data_live),
		.push              (push),
		.data_hwvld        (data_hwvld)
	);

	// A jump empties the queue along with the CIR
	prefetch_queue i_queue (
		.clk               (clk),
		.rst_n             (rst_n),
		.flush             (jump_now),
		.push              (push),
		.pop               (pop),
		.mem_data          (mem_data),
		.mem_data_err      (mem_data_err),
		.data_hwvld        (data_hwvld),
		.head_data         (head_data),
		.head_hwvld        (head_hwvld),
		.head_err          (head_err),
		.head_valid        (head_valid),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full)
	);

	instr_assembly i_assembly (
		.clk               (clk),
		.rst_n             (rst_n),
		.jump_now          (jump_now),
		.cir_flush_behind  (cir_flush_behind),
		.mem_data          (mem_data),
		.mem_data_err      (mem_data_err),
		.data_live         (data_live),
		.data_hwvld        (data_hwvld),
		.head_data         (head_data),
		.head_hwvld        (head_hwvld),
		.head_err          (head_err),
		.head_valid        (head_valid),
		.cir_use           (cir_use),
		.cir               (cir),
		.cir_vld           (cir_vld),
		.cir_err           (cir_err),
		.room              (room),
		.pop               (pop)
	);

endmodule

/* bench/tb_fetch_frontend.sv */
// Fetch front end testbench
`timescale 1ns/1ps

module tb_fetch_frontend;

	logic        clk;
	logic        rst_n;
	logic [31:0] mem_addr;
	logic        mem_addr_vld;
	logic        mem_addr_rdy;
	logic [31:0] mem_data;
	logic        mem_data_err;
	logic        mem_data_vld;
	logic [31:0] jump_target;
	logic        jump_target_vld;
	logic        jump_target_rdy;
	logic        cir_flush_behind;
	logic [31:0] cir;
	logic [1:0]  cir_vld;
	logic [1:0]  cir_err;
	logic [1:0]  cir_use;

	// Halfword image where the word at address A is image[A/2] and image[A/2+1]
	logic [15:0] image [1024];
	int          seed;
	int          error_count;

	// Memory model state holds one entry per accepted address in order
	logic [31:0] pend_addr [$];
	int          pend_lat [$];
	logic        rdy_stalls;
	logic        held;
	logic [31:0] held_addr;
	logic        first_seen;
	logic [31:0] first_addr;

	// Decode model state
	logic        decode_on;
	logic        dec_stalls;
	logic        dec_hold;
	logic [31:0] pc;
	int          consumed;
	int          n16;
	int          n_straddle;
	int          n_err;
	logic        jump_req;
	logic        jump_fb;
	logic [31:0] jump_addr;
	logic        jump_taken;
	logic        redirect_pending;

	fetch_frontend i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	function automatic logic err_at(input logic [31:0] a);
		return (a >= 32'h600) && (a < 32'h640);
	endfunction

	function automatic logic [15:0] hw_at(input logic [31:0] a);
		return image[(a >> 1) & 32'h3ff];
	endfunction

	// ------------------------------------------------------------------------
	// Bus memory model

	// Drive ready and return data beats in order on the falling edge
	always @(negedge clk) begin
		mem_data_vld = 1'b0;
		if (rst_n) begin
			mem_addr_rdy = !rdy_stalls || (($random(seed) & 3) != 0);
			if (pend_addr.size() > 0) begin
				if (pend_lat[0] <= 1) begin
					mem_data     = {hw_at(pend_addr[0] + 2), hw_at(pend_addr[0])};
					mem_data_err = err_at(pend_addr[0]);
					mem_data_vld = 1'b1;
					void'(pend_addr.pop_front());
					void'(pend_lat.pop_front());
				end else begin
					pend_lat[0] = pend_lat[0] - 1;
				end
			end
		end
	end

	// Sample the address phase just before the rising edge where it is stable
	always @(negedge clk) begin
		#9;
		if (rst_n) begin
			// Jumps may only be refused while an address phase is held
			compare(jump_target_rdy, !held, "jump_target_rdy");
			if (held) begin
				compare(mem_addr_vld, 1'b1, "held mem_addr_vld");
				compare(mem_addr, held_addr, "held mem_addr");
			end
			if (mem_addr_vld && mem_addr_rdy) begin
				pend_addr.push_back(mem_addr);
				pend_lat.push_back(1 + ({$random(seed)} % 3));
				if (!first_seen) begin
					first_seen = 1'b1;
					first_addr = mem_addr;
				end
				compare(pend_addr.size() <= fetch_pkg::max_pending, 1'b1, "outstanding limit");
			end
			held       = mem_addr_vld && !mem_addr_rdy;
			held_addr  = mem_addr;
			jump_taken = jump_target_vld && jump_target_rdy;
			// Decode stall for the next cycle is drawn here to keep the random order fixed
			dec_hold   = dec_stalls && ($random(seed) & 1);
		end
	end

	// ------------------------------------------------------------------------
	// Decode model

	always @(negedge clk) begin
		if (jump_taken) begin
			jump_taken      = 1'b0;
			jump_target_vld = 1'b0;
			if (jump_fb) begin
				redirect_pending = 1'b1;
			end else begin
				pc = jump_addr;
			end
			cir_flush_behind = 1'b0;
			jump_req         = 1'b0;
		end
		cir_use = 2'd0;
		if (jump_req && !jump_target_vld) begin
			// Flush-behind needs a whole instruction in the CIR to keep
			if (!jump_fb || cir_vld == 2'd2 || (cir_vld != 2'd0 && cir[1:0] != 2'b11)) begin
				jump_target      = jump_addr;
				jump_target_vld  = 1'b1;
				cir_flush_behind = jump_fb;
			end
		end
		if (decode_on && !jump_target_vld && !dec_hold) begin
			if (cir_vld != 2'd0 && cir[1:0] != 2'b11) begin
				cir_use = 2'd1;
			end else if (cir_vld == 2'd2 && cir[1:0] == 2'b11) begin
				cir_use = 2'd2;
			end
		end
		if (cir_use != 2'd0) begin
			compare(cir[15:0], hw_at(pc), "instruction low half");
			compare(cir_err[0], err_at(pc), "low half error");
			n_err += cir_err[0];
			if (cir_use == 2'd2) begin
				compare(cir[31:16], hw_at(pc + 2), "instruction high half");
				compare(cir_err[1], err_at(pc + 2), "high half error");
				n_err += cir_err[1];
				// A 32-bit instruction at an odd halfword spans two bus words
				if (pc[1]) begin
					n_straddle++;
				end
			end else begin
				n16++;
			end
			pc = pc + 32'(cir_use) * 2;
			consumed++;
			if (redirect_pending) begin
				redirect_pending = 1'b0;
				pc = jump_addr;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Directed tests

	task automatic wait_consumed(input int count);
		int target;
		int cycles;
		target = consumed + count;
		cycles = 0;
		while (consumed < target) begin
			@(posedge clk);
			cycles++;
			if (cycles > 3000) begin
				$display("Timeout: decode stopped receiving instructions at %0t ns", $time);
				$display("sim failed");
				$fatal(1);
			end
		end
	endtask

	task automatic jump_to(input logic [31:0] target, input logic fb);
		int cycles;
		cycles    = 0;
		jump_addr = target;
		jump_fb   = fb;
		jump_req  = 1'b1;
		while (jump_req) begin
			@(posedge clk);
			cycles++;
			if (cycles > 200) begin
				$display("Timeout: jump request was never accepted at %0t ns", $time);
				$display("sim failed");
				$fatal(1);
			end
		end
	endtask

	task automatic reset_test();
		int cycles;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		compare(cir_vld, 2'd0, "cir_vld in reset");
		compare(mem_addr_vld, 1'b0, "mem_addr_vld in reset");
		compare(jump_target_rdy, 1'b1, "jump_target_rdy in reset");
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		compare(mem_addr_vld, 1'b0, "mem_addr_vld after reset");
		cycles = 0;
		while (!first_seen) begin
			@(posedge clk);
			cycles++;
			if (cycles > 50) begin
				$display("Timeout: no fetch request after reset");
				$display("sim failed");
				$fatal(1);
			end
		end
		compare(first_addr, fetch_pkg::reset_vector, "first fetch address");
	endtask

	task automatic sequential_test();
		decode_on = 1'b1;
		wait_consumed(40);
		// Region below 0x400 holds only 32-bit instructions
		compare(n16, 0, "16-bit count in 32-bit stream");
	endtask

	task automatic mixed_test();
		jump_to(32'h402, 1'b0);
		wait_consumed(80);
		compare(n16 > 0 && n_straddle > 0, 1'b1, "mixed lengths seen");
	endtask

	task automatic flush_behind_test();
		jump_to(32'h480, 1'b1);
		wait_consumed(30);
		jump_to(32'h4c6, 1'b0);
		wait_consumed(30);
	endtask

	task automatic bus_error_test();
		jump_to(32'h5f0, 1'b0);
		wait_consumed(60);
		compare(n_err > 0, 1'b1, "error halfwords seen");
	endtask

	task automatic backpressure_test();
		rdy_stalls = 1'b1;
		dec_stalls = 1'b1;
		jump_to(32'h80, 1'b0);
		wait_consumed(50);
		jump_to(32'h700, 1'b1);
		wait_consumed(50);
	endtask

	initial begin
		logic [31:0] h;
		seed             = 32'hc726_4104;
		error_count      = 0;
		rst_n            = 1'b0;
		mem_addr_rdy     = 1'b1;
		mem_data         = '0;
		mem_data_err     = 1'b0;
		mem_data_vld     = 1'b0;
		jump_target      = '0;
		jump_target_vld  = 1'b0;
		cir_flush_behind = 1'b0;
		cir_use          = 2'd0;
		rdy_stalls       = 1'b0;
		dec_stalls       = 1'b0;
		dec_hold         = 1'b0;
		held             = 1'b0;
		first_seen       = 1'b0;
		decode_on        = 1'b0;
		pc               = fetch_pkg::reset_vector;
		consumed         = 0;
		n16              = 0;
		n_straddle       = 0;
		n_err            = 0;
		jump_req         = 1'b0;
		jump_fb          = 1'b0;
		jump_addr        = '0;
		jump_taken       = 1'b0;
		redirect_pending = 1'b0;
		// Low half lists 32-bit instructions only and high half mixes both lengths
		for (int i = 0; i < 1024; i++) begin
			h = i * 32'h9e37_79b1;
			if (i >= 512) begin
				h = $random(seed);
				image[i] = h[15:0];
			end else if (i % 2 == 0) begin
				image[i] = {h[31:18] ^ h[13:0], 2'b11};
			end else begin
				image[i] = h[31:16] ^ h[15:0];
			end
		end
		reset_test();
		sequential_test();
		mixed_test();
		flush_behind_test();
		bus_error_test();
		backpressure_test();
		if (error_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

/* files.f */
hdl/fetch_pkg.sv
hdl/rvc_pkg.sv
hdl/fetch_request.sv
hdl/prefetch_queue.sv
hdl/instr_assembly.sv
hdl/fetch_frontend.sv
bench/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/rvc_pkg.sv
      - hdl/fetch_request.sv
      - hdl/prefetch_queue.sv
      - hdl/instr_assembly.sv
      - hdl/fetch_frontend.sv
  - target: simulation
    files:
      - bench/tb_fetch_frontend.sv
